// ==== hw/aes_stream_pkg.sv ====
`default_nettype none

package aes_stream_pkg;

        // ====================
        // Widths and depth
        // ====================
        localparam int WORD_W          = 32;
        localparam int WORDS_PER_BLOCK = 4;
        localparam int BLOCK_W         = WORD_W * WORDS_PER_BLOCK;

        // Longest frame is one full RAM
        localparam int RAM_DEPTH       = 16;
        localparam int ADDR_W          = $clog2(RAM_DEPTH);

        // ====================
        // Shared types
        // ====================
        typedef logic [WORD_W-1:0]  word_t;
        typedef logic [BLOCK_W-1:0] block_t;
        typedef logic [ADDR_W-1:0]  addr_t;
        // One extra bit so a full RAM (16 blocks) fits
        typedef logic [ADDR_W:0]    count_t;
        typedef logic [1:0]         word_idx_t;

endpackage

`default_nettype wire

// ==== hw/ram_if.sv ====
`default_nettype none

interface ram_if
        import aes_stream_pkg::*;
();

        // Write port
        logic   wr_en;
        addr_t  wr_addr;
        block_t wr_data;

        // Read port with data one cycle after rd_en
        logic   rd_en;
        addr_t  rd_addr;
        block_t rd_data;

        modport writer (output wr_en, wr_addr, wr_data);
        modport reader (output rd_en, rd_addr, input rd_data);
        modport ram (input wr_en, wr_addr, wr_data, rd_en, rd_addr, output rd_data);

endinterface

`default_nettype wire

// ==== hw/block_ram.sv ====
`default_nettype none

module block_ram
        import aes_stream_pkg::*;
(
        input wire logic s00_axis_aclk,
        ram_if.ram       bus
);

        block_t mem [RAM_DEPTH];

        // Write side
        always_ff @(posedge s00_axis_aclk) begin
                if (bus.wr_en) begin
                        mem[bus.wr_addr] <= bus.wr_data;
                end
        end

        // Registered read that holds its output between reads
        always_ff @(posedge s00_axis_aclk) begin
                if (bus.rd_en) begin
                        bus.rd_data <= mem[bus.rd_addr];
                end
        end

endmodule

`default_nettype wire

// ==== hw/rx_deframer.sv ====
`default_nettype none

module rx_deframer
        import aes_stream_pkg::*;
(
        input wire logic  s00_axis_aclk,
        input wire logic  reset,
        input wire word_t s00_axis_tdata,
        input wire logic  s00_axis_tvalid,
        input wire logic  s00_axis_tlast,
        output logic      s00_axis_tready,
        input wire logic  rx_req,
        output logic      rx_ack,
        output word_t     frame_key,
        output count_t    frame_blocks,
        ram_if.writer     ram
);

        logic      accept;
        logic      have_key;
        logic      done;
        logic      block_end;
        logic      closing;
        word_idx_t word_idx;
        addr_t     blk_addr;
        block_t    block_reg;

        assign s00_axis_tready = rx_req && !done;
        assign accept          = s00_axis_tvalid && s00_axis_tready;

        // TLAST only counts on the last word of a block
        assign block_end = have_key && (word_idx == word_idx_t'(WORDS_PER_BLOCK - 1));
        assign closing   = block_end && (s00_axis_tlast || blk_addr == addr_t'(RAM_DEPTH - 1));

        assign ram.wr_data = block_reg;

        // ====================
        // Frame control
        // ====================
        always_ff @(posedge s00_axis_aclk) begin
                if (reset) begin
                        have_key  <= 1'b0;
                        done      <= 1'b0;
                        word_idx  <= '0;
                        blk_addr  <= '0;
                        ram.wr_en <= 1'b0;
                        rx_ack    <= 1'b0;
                end else begin
                        ram.wr_en <= 1'b0;
                        if (!rx_req) begin
                                done   <= 1'b0;
                                rx_ack <= 1'b0;
                        end else if (ram.wr_en && done) begin
                                // Closing block is now in the RAM
                                rx_ack <= 1'b1;
                        end
                        if (accept) begin
                                if (!have_key) begin
                                        have_key <= 1'b1;
                                end else begin
                                        word_idx <= word_idx + 1'b1;
                                        if (block_end) begin
                                                ram.wr_en <= 1'b1;
                                                blk_addr  <= blk_addr + 1'b1;
                                        end
                                        if (closing) begin
                                                done     <= 1'b1;
                                                have_key <= 1'b0;
                                                blk_addr <= '0;
                                        end
                                end
                        end
                end
        end

        // ====================
        // Payload capture
        // ====================
        always_ff @(posedge s00_axis_aclk) begin
                if (accept && !have_key) begin
                        frame_key <= s00_axis_tdata;
                end
                // First word ends up most significant
                if (accept && have_key) begin
                        block_reg <= {block_reg[BLOCK_W-WORD_W-1:0], s00_axis_tdata};
                end
                if (accept && block_end) begin
                        ram.wr_addr <= blk_addr;
                end
                if (accept && closing) begin
                        frame_blocks <= count_t'(blk_addr) + 1'b1;
                end
        end

endmodule

`default_nettype wire

// ==== hw/frame_control.sv ====
`default_nettype none

module frame_control (
        input wire logic s00_axis_aclk,
        input wire logic reset,
        output logic     rx_req,
        input wire logic rx_ack,
        output logic     eng_req,
        input wire logic eng_ack,
        output logic     tx_req,
        input wire logic tx_ack
);

        typedef enum logic [1:0] {
                RECEIVE,
                PROCESS,
                SEND,
                RELEASE
        } frame_state_t;

        frame_state_t state;

        // Each req rises once its ack is low and drops when the ack rises
        always_ff @(posedge s00_axis_aclk) begin
                if (reset) begin
                        state   <= RECEIVE;
                        rx_req  <= 1'b0;
                        eng_req <= 1'b0;
                        tx_req  <= 1'b0;
                end else begin
                        case (state)
                                RECEIVE: begin
                                        if (rx_req && rx_ack) begin
                                                rx_req <= 1'b0;
                                                state  <= PROCESS;
                                        end else if (!rx_ack) begin
                                                rx_req <= 1'b1;
                                        end
                                end
                                PROCESS: begin
                                        if (eng_req && eng_ack) begin
                                                eng_req <= 1'b0;
                                                state   <= SEND;
                                        end else if (!eng_ack) begin
                                                eng_req <= 1'b1;
                                        end
                                end
                                SEND: begin
                                        if (tx_req && tx_ack) begin
                                                tx_req <= 1'b0;
                                                state  <= RELEASE;
                                        end else if (!tx_ack) begin
                                                tx_req <= 1'b1;
                                        end
                                end
                                // Hold off the next frame until the sender lets go
                                RELEASE: begin
                                        if (!tx_ack) begin
                                                state <= RECEIVE;
                                        end
                                end
                                default: state <= RECEIVE;
                        endcase
                end
        end

endmodule

`default_nettype wire

// ==== hw/whitening_engine.sv ====
`default_nettype none

module whitening_engine
        import aes_stream_pkg::*;
(
        input wire logic   s00_axis_aclk,
        input wire logic   reset,
        input wire logic   eng_req,
        output logic       eng_ack,
        input wire word_t  frame_key,
        input wire count_t frame_blocks,
        ram_if.reader      src,
        ram_if.writer      dst
);

        logic   busy;
        logic   start;
        logic   issue;
        logic   rd_valid;
        logic   last_write;
        count_t issued;
        addr_t  addr_d;
        block_t round_key;

        // AddRoundKey with the command word in every lane
        assign round_key = {WORDS_PER_BLOCK{frame_key}};

        assign start      = !busy && eng_req && !eng_ack;
        assign issue      = (start || busy) && (issued != frame_blocks);
        assign last_write = dst.wr_en && (count_t'(dst.wr_addr) == frame_blocks - 1'b1);

        always_ff @(posedge s00_axis_aclk) begin
                if (reset) begin
                        busy      <= 1'b0;
                        issued    <= '0;
                        src.rd_en <= 1'b0;
                        rd_valid  <= 1'b0;
                        dst.wr_en <= 1'b0;
                        eng_ack   <= 1'b0;
                end else begin
                        // Read, then XOR register, then write
                        src.rd_en <= issue;
                        rd_valid  <= src.rd_en;
                        dst.wr_en <= rd_valid;
                        if (start) begin
                                busy <= 1'b1;
                        end
                        if (issue) begin
                                issued <= issued + 1'b1;
                        end
                        if (last_write) begin
                                busy    <= 1'b0;
                                issued  <= '0;
                                eng_ack <= 1'b1;
                        end else if (!eng_req) begin
                                eng_ack <= 1'b0;
                        end
                end
        end

        // Address and data pipeline
        always_ff @(posedge s00_axis_aclk) begin
                if (issue) begin
                        src.rd_addr <= addr_t'(issued);
                end
                addr_d      <= src.rd_addr;
                dst.wr_addr <= addr_d;
                dst.wr_data <= src.rd_data ^ round_key;
        end

endmodule

`default_nettype wire

// ==== hw/tx_serializer.sv ====
`default_nettype none

module tx_serializer
        import aes_stream_pkg::*;
(
        input wire logic   s00_axis_aclk,
        input wire logic   reset,
        input wire logic   tx_req,
        output logic       tx_ack,
        input wire count_t frame_blocks,
        ram_if.reader      src,
        output word_t      m00_axis_tdata,
        output logic       m00_axis_tvalid,
        output logic       m00_axis_tlast,
        input wire logic   m00_axis_tready
);

        typedef enum logic [1:0] {
                TX_IDLE,
                TX_WAIT,
                TX_LOAD,
                TX_SEND
        } tx_state_t;

        tx_state_t state;
        block_t    shift_reg;
        word_idx_t word_idx;
        addr_t     blk_idx;
        logic      xfer;
        logic      block_end;
        logic      last_word;

        assign m00_axis_tdata = shift_reg[BLOCK_W-1 -: WORD_W];
        assign xfer           = m00_axis_tvalid && m00_axis_tready;
        assign block_end      = (word_idx == word_idx_t'(WORDS_PER_BLOCK - 1));
        assign last_word      = block_end && (count_t'(blk_idx) == frame_blocks - 1'b1);
        assign m00_axis_tlast = last_word;

        // ====================
        // Sequencing
        // ====================
        always_ff @(posedge s00_axis_aclk) begin
                if (reset) begin
                        state           <= TX_IDLE;
                        m00_axis_tvalid <= 1'b0;
                        tx_ack          <= 1'b0;
                        src.rd_en       <= 1'b0;
                        word_idx        <= '0;
                        blk_idx         <= '0;
                end else begin
                        src.rd_en <= 1'b0;
                        if (!tx_req) begin
                                tx_ack <= 1'b0;
                        end
                        case (state)
                                TX_IDLE: begin
                                        if (tx_req && !tx_ack) begin
                                                src.rd_en <= 1'b1;
                                                state     <= TX_WAIT;
                                        end
                                end
                                TX_WAIT: state <= TX_LOAD;
                                // Block 0 is on rd_data while block 1 is fetched
                                TX_LOAD: begin
                                        src.rd_en       <= 1'b1;
                                        m00_axis_tvalid <= 1'b1;
                                        word_idx        <= '0;
                                        blk_idx         <= '0;
                                        state           <= TX_SEND;
                                end
                                TX_SEND: begin
                                        if (xfer) begin
                                                word_idx <= word_idx + 1'b1;
                                                if (last_word) begin
                                                        m00_axis_tvalid <= 1'b0;
                                                        tx_ack          <= 1'b1;
                                                        state           <= TX_IDLE;
                                                end else if (block_end) begin
                                                        blk_idx   <= blk_idx + 1'b1;
                                                        src.rd_en <= 1'b1;
                                                end
                                        end
                                end
                                default: state <= TX_IDLE;
                        endcase
                end
        end

        // ====================
        // Word shifter
        // ====================
        always_ff @(posedge s00_axis_aclk) begin
                if (state == TX_IDLE) begin
                        src.rd_addr <= '0;
                end else if (state == TX_LOAD) begin
                        src.rd_addr <= src.rd_addr + 1'b1;
                end else if (xfer && block_end) begin
                        src.rd_addr <= blk_idx + addr_t'(2);
                end
                if (state == TX_LOAD || (xfer && block_end)) begin
                        shift_reg <= src.rd_data;
                end else if (xfer) begin
                        shift_reg <= shift_reg << WORD_W;
                end
        end

endmodule

`default_nettype wire

// ==== hw/aes_stream_top.sv ====
`default_nettype none

module aes_stream_top
        import aes_stream_pkg::*;
(
        input wire logic  s00_axis_aclk,
        input wire logic  reset,
        input wire word_t s00_axis_tdata,
        input wire logic  s00_axis_tvalid,
        input wire logic  s00_axis_tlast,
        output logic      s00_axis_tready,
        output word_t     m00_axis_tdata,
        output logic      m00_axis_tvalid,
        output logic      m00_axis_tlast,
        input wire logic  m00_axis_tready
);

        logic   rx_req;
        logic   rx_ack;
        logic   eng_req;
        logic   eng_ack;
        logic   tx_req;
        logic   tx_ack;
        word_t  frame_key;
        count_t frame_blocks;

        ram_if in_ram_bus ();
        ram_if out_ram_bus ();

        // ====================
        // Storage
        // ====================
        block_ram in_ram (.s00_axis_aclk, .bus(in_ram_bus));
        block_ram out_ram (.s00_axis_aclk, .bus(out_ram_bus));

        // ====================
        // Stages
        // ====================
        frame_control frame_control_i (
                .s00_axis_aclk, .reset,
                .rx_req, .rx_ack, .eng_req, .eng_ack, .tx_req, .tx_ack
        );

        rx_deframer rx_deframer_i (
                .s00_axis_aclk, .reset,
                .s00_axis_tdata, .s00_axis_tvalid, .s00_axis_tlast, .s00_axis_tready,
                .rx_req, .rx_ack, .frame_key, .frame_blocks,
                .ram(in_ram_bus)
        );

        whitening_engine whitening_engine_i (
                .s00_axis_aclk, .reset,
                .eng_req, .eng_ack, .frame_key, .frame_blocks,
                .src(in_ram_bus),
                .dst(out_ram_bus)
        );

        tx_serializer tx_serializer_i (
                .s00_axis_aclk, .reset,
                .tx_req, .tx_ack, .frame_blocks,
                .src(out_ram_bus),
                .m00_axis_tdata, .m00_axis_tvalid, .m00_axis_tlast, .m00_axis_tready
        );

endmodule

`default_nettype wire

// ==== test/tb_aes_stream_props.sv ====
`default_nettype none

module aes_stream_props
        import aes_stream_pkg::*;
(
        input wire logic  s00_axis_aclk,
        input wire logic  reset,
        input wire logic  s00_axis_tready,
        input wire word_t m00_axis_tdata,
        input wire logic  m00_axis_tvalid,
        input wire logic  m00_axis_tlast,
        input wire logic  m00_axis_tready
);

        timeunit 1ns;
        timeprecision 1ps;

        // ====================
        // Master stream
        // ====================
        hold_under_backpressure: assert property (@(posedge s00_axis_aclk) disable iff (reset)
                (m00_axis_tvalid && !m00_axis_tready) |=>
                (m00_axis_tvalid && $stable(m00_axis_tdata) && $stable(m00_axis_tlast)))
                else $error("Master stream changed while stalled");

        tlast_needs_tvalid: assert property (@(posedge s00_axis_aclk) disable iff (reset)
                m00_axis_tlast |-> m00_axis_tvalid)
                else $error("m00_axis_tlast high without m00_axis_tvalid");

        // Both streams quiet right after reset
        quiet_after_reset: assert property (@(posedge s00_axis_aclk)
                reset |=> (!s00_axis_tready && !m00_axis_tvalid))
                else $error("Stream handshake active after reset");

endmodule

bind aes_stream_top aes_stream_props props_i (.*);

`default_nettype wire

// ==== test/tb_aes_stream.sv ====
`default_nettype none

module tb_aes_stream
        import aes_stream_pkg::*;
();

        timeunit 1ns;
        timeprecision 1ps;

        // About 200 words in and out at under 25 cycles each
        localparam int TIMEOUT_CYCLES = 200 * 25;

        logic        s00_axis_aclk;
        logic        reset;
        word_t       s00_axis_tdata;
        logic        s00_axis_tvalid;
        logic        s00_axis_tlast;
        logic        s00_axis_tready;
        word_t       m00_axis_tdata;
        logic        m00_axis_tvalid;
        logic        m00_axis_tlast;
        logic        m00_axis_tready;
        logic [15:0] lfsr_state;
        int          cycle_count = 0;
        word_t       payload_q[$];

        aes_stream_top dut_i (.*);

        initial begin
                s00_axis_aclk = 1'b0;
                forever #50 s00_axis_aclk = ~s00_axis_aclk;
        end

        always @(posedge s00_axis_aclk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= TIMEOUT_CYCLES) begin
                        $display("Timed out after %0d cycles waiting on the DUT", cycle_count);
                        $display("Simulation FAILED");
                        $fatal(1, "Run stopped by the cycle limit");
                end
        end

        // ====================
        // Helpers
        // ====================
        // Taps 16, 14, 13, 11
        function automatic logic [15:0] lfsr_step(input logic [15:0] state);
                logic feedback;
                feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
                return {state[14:0], feedback};
        endfunction

        task automatic take_bits(input int count, output word_t bits);
                int i;
                bits = '0;
                for (i = 0; i < count; i++) begin
                        lfsr_state = lfsr_step(lfsr_state);
                        bits = {bits[WORD_W-2:0], lfsr_state[0]};
                end
        endtask

        task automatic check_value(input string name, input word_t expected, input word_t actual);
                if (actual !== expected) begin
                        $display("Fail %s expected 0x%h actual 0x%h", name, expected, actual);
                        $display("Simulation FAILED");
                        $fatal(1, "Mismatch on %s", name);
                end
        endtask

        task automatic check_idle(input int cycles, input logic in_reset);
                repeat (cycles) begin
                        @(negedge s00_axis_aclk);
                        check_value("m00_axis_tvalid", '0, word_t'(m00_axis_tvalid));
                        check_value("m00_axis_tlast", '0, word_t'(m00_axis_tlast));
                        if (in_reset) begin
                                check_value("s00_axis_tready", '0, word_t'(s00_axis_tready));
                        end
                        @(posedge s00_axis_aclk);
                end
        endtask

        task automatic fill_payload(input int n_blocks);
                word_t value;
                int    i;
                payload_q.delete();
                for (i = 0; i < n_blocks * WORDS_PER_BLOCK; i++) begin
                        take_bits(WORD_W, value);
                        payload_q.push_back(value);
                end
        endtask

        // Holds the word until the DUT takes it
        task automatic drive_word(input word_t data, input logic last);
                logic accepted;
                s00_axis_tdata  = data;
                s00_axis_tvalid = 1'b1;
                s00_axis_tlast  = last;
                accepted        = 1'b0;
                while (!accepted) begin
                        @(negedge s00_axis_aclk);
                        accepted = s00_axis_tready;
                        @(posedge s00_axis_aclk);
                        #5;
                end
                s00_axis_tvalid = 1'b0;
                s00_axis_tlast  = 1'b0;
        endtask

        task automatic send_frame(input word_t key, input logic mark_last);
                int i;
                drive_word(key, 1'b0);
                for (i = 0; i < payload_q.size(); i++) begin
                        drive_word(payload_q[i], mark_last && (i == payload_q.size() - 1));
                end
        endtask

        // Each output word is its input word XOR the key
        task automatic receive_frame(input word_t key, input logic backpressure);
                int    index;
                word_t ready_bit;
                index = 0;
                while (index < payload_q.size()) begin
                        ready_bit = 32'h1;
                        if (backpressure) begin
                                take_bits(1, ready_bit);
                        end
                        m00_axis_tready = ready_bit[0];
                        @(negedge s00_axis_aclk);
                        if (m00_axis_tvalid && m00_axis_tready) begin
                                check_value("m00_axis_tdata", payload_q[index] ^ key, m00_axis_tdata);
                                check_value("m00_axis_tlast", word_t'(index == payload_q.size() - 1),
                                            word_t'(m00_axis_tlast));
                                index++;
                        end
                        @(posedge s00_axis_aclk);
                        #5;
                end
                m00_axis_tready = 1'b0;
                // Nothing may follow the last word
                @(negedge s00_axis_aclk);
                check_value("m00_axis_tvalid", '0, word_t'(m00_axis_tvalid));
                @(posedge s00_axis_aclk);
                #5;
        endtask

        task automatic run_frame(input word_t key, input int n_blocks, input logic mark_last,
                                 input logic backpressure);
                fill_payload(n_blocks);
                send_frame(key, mark_last);
                receive_frame(key, backpressure);
        endtask

        // ====================
        // Directed tests
        // ====================
        task automatic test_after_reset();
                reset = 1'b1;
                check_idle(10, 1'b1);
                #5;
                reset = 1'b0;
                check_idle(5, 1'b0);
                #5;
        endtask

        task automatic test_single_block();
                run_frame(32'h0f1e2d3c, 1, 1'b1, 1'b0);
        endtask

        task automatic test_multi_block();
                run_frame(32'ha5c3_961e, 3, 1'b1, 1'b0);
        endtask

        task automatic test_backpressure();
                run_frame(32'h5a3c_69e1, 3, 1'b1, 1'b1);
        endtask

        // No TLAST, so the frame closes on a full input RAM
        task automatic test_full_buffer();
                run_frame(32'hdead_beef, RAM_DEPTH, 1'b0, 1'b0);
                run_frame(32'h1357_9bdf, 2, 1'b1, 1'b0);
        endtask

        initial begin
                reset           = 1'b1;
                s00_axis_tdata  = '0;
                s00_axis_tvalid = 1'b0;
                s00_axis_tlast  = 1'b0;
                m00_axis_tready = 1'b0;
                lfsr_state      = 16'd12656;

                test_after_reset();
                test_single_block();
                test_multi_block();
                test_backpressure();
                test_full_buffer();

                $display("Simulation PASSED");
                $finish;
        end

endmodule

`default_nettype wire

// ==== project.f ====
hw/aes_stream_pkg.sv
hw/ram_if.sv
hw/block_ram.sv
hw/rx_deframer.sv
hw/frame_control.sv
hw/whitening_engine.sv
hw/tx_serializer.sv
hw/aes_stream_top.sv
test/tb_aes_stream_props.sv
test/tb_aes_stream.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_aes_stream -Mdir obj_dir -f project.f

./obj_dir/Vtb_aes_stream > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log || ! grep -q "Simulation PASSED" sim.log; then
        echo "Simulation run did not pass, see sim.log"
        exit 1
fi
